// File: logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////

	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int IMEM_DEPTH = 64; // instruction words
	localparam int DMEM_DEPTH = 64; // data words
	localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
	localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

	//////////////////////////////////////////////////
	// opcodes and function codes
	//////////////////////////////////////////////////

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_HALT  = 6'h3f; // not a MIPS opcode

	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		SLT
	} alu_op_e;

	//////////////////////////////////////////////////
	// instruction word, R and I views
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0]            opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [4:0]            shamt;
		logic [5:0]            funct;
	} instr_r_t;

	typedef struct packed {
		logic [5:0]            opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [15:0]           imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm; // b operand from imm
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
		logic    mem_to_reg;  // wb takes load data
		logic    branch;
	} ctrl_t;

	//////////////////////////////////////////////////
	// stage registers, all zero is a bubble
	//////////////////////////////////////////////////

	typedef struct packed {
		instr_u            instr;
		logic [DATA_W-1:0] pc_plus4;
		logic              valid;
	} if_id_t;

	typedef struct packed {
		ctrl_t                 ctrl;
		logic [DATA_W-1:0]     reg1;
		logic [DATA_W-1:0]     reg2;
		logic [DATA_W-1:0]     imm;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] dest;
		logic [DATA_W-1:0]     pc_plus4;
		logic                  halt;
	} id_ex_t;

	typedef struct packed {
		ctrl_t                 ctrl;
		logic [DATA_W-1:0]     alu;
		logic [DATA_W-1:0]     store_data;
		logic [REG_ADDR_W-1:0] dest;
		logic [DATA_W-1:0]     branch_target;
		logic                  zero;
		logic                  halt;
	} ex_mem_t;

	typedef struct packed {
		logic                  reg_write;
		logic [REG_ADDR_W-1:0] dest;
		logic [DATA_W-1:0]     data;
		logic                  halt;
	} mem_wb_t;

endpackage

`default_nettype wire

// File: logic/instruction_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_fetch (
	input  wire logic                          clk,
	input  wire logic                          arst_n,
	input  wire logic                          run,
	input  wire logic                          halt,
	input  wire logic                          stall,
	input  wire logic                          hold,
	input  wire logic                          flush,
	input  wire logic [mips_pkg::DATA_W-1:0]   branch_target,
	input  wire logic                          load_req,
	input  wire logic [mips_pkg::IMEM_AW-1:0]  load_addr,
	input  wire logic [mips_pkg::DATA_W-1:0]   load_data,
	output logic                               load_ack,
	output logic [mips_pkg::DATA_W-1:0]        pc,
	output mips_pkg::if_id_t                   if_id
);
	import mips_pkg::*;

	logic [DATA_W-1:0] imem [IMEM_DEPTH];
	logic [DATA_W-1:0] pc_plus4;
	logic [DATA_W-1:0] instr_word;
	logic              step;

	assign step       = run && !halt; // pipeline advance
	assign pc_plus4   = pc + DATA_W'(4);
	assign instr_word = imem[pc[IMEM_AW+1:2]]; // word addressed

	//////////////////////////////////////////////////
	// host load, four-phase req/ack
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (load_req && !load_ack)
			imem[load_addr] <= load_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			load_ack <= 1'b0;
		else if (load_req && !load_ack)
			load_ack <= 1'b1; // word written
		else if (!load_req && load_ack)
			load_ack <= 1'b0; // host released req
	end

	//////////////////////////////////////////////////
	// pc and IF/ID
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (step) begin
			if (flush)
				pc <= branch_target; // taken beq from MEM
			else if (!stall && !hold)
				pc <= pc_plus4;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id <= '0;
		end else if (step) begin
			if (flush || hold)
				if_id <= '0;
			else if (!stall) begin
				if_id.instr    <= instr_word;
				if_id.pc_plus4 <= pc_plus4;
				if_id.valid    <= 1'b1;
			end
		end
	end

	// host may only start a load while the core is stopped
	a_load_stopped: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(load_req) |-> !run);

endmodule

`default_nettype wire

// File: logic/decode.sv
`timescale 1ns/1ns
`default_nettype none

module decode (
	input  wire logic                            clk,
	input  wire logic                            arst_n,
	input  wire logic                            run,
	input  wire logic                            halt,
	input  wire logic                            flush,
	input  wire mips_pkg::if_id_t                if_id,
	input  wire mips_pkg::mem_wb_t               mem_wb,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0] dbg_addr,
	output mips_pkg::id_ex_t                     id_ex,
	output logic                                 stall,
	output logic                                 hold,
	output logic [mips_pkg::DATA_W-1:0]          dbg_reg
);
	import mips_pkg::*;

	logic [DATA_W-1:0]     regs [2**REG_ADDR_W];
	instr_u                instr;
	logic [REG_ADDR_W-1:0] rs;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] dest;
	logic [DATA_W-1:0]     rd1;
	logic [DATA_W-1:0]     rd2;
	logic [DATA_W-1:0]     imm_ext;
	ctrl_t                 ctrl;
	id_ex_t                id_ex_d;
	logic                  uses_rs;
	logic                  uses_rt;
	logic                  is_halt;
	logic                  hold_q;
	logic                  rf_we;
	logic                  step;

	assign step    = run && !halt;
	assign instr   = if_id.instr;
	assign rs      = instr.i.rs;
	assign rt      = instr.r.rt;
	assign imm_ext = {{(DATA_W-16){instr.i.imm[15]}}, instr.i.imm};

	//////////////////////////////////////////////////
	// control decode
	//////////////////////////////////////////////////

	always_comb begin
		ctrl    = '0;
		dest    = instr.i.rt;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		is_halt = 1'b0;
		if (if_id.valid) begin
			case (instr.r.opcode)
				OP_RTYPE: begin
					dest           = instr.r.rd;
					uses_rs        = 1'b1;
					uses_rt        = 1'b1;
					ctrl.reg_write = 1'b1;
					case (instr.r.funct)
						FN_ADDU: ctrl.alu_op = ADD;
						FN_SUBU: ctrl.alu_op = SUB;
						FN_AND:  ctrl.alu_op = AND;
						FN_OR:   ctrl.alu_op = OR;
						FN_SLT:  ctrl.alu_op = SLT;
						default: ctrl.reg_write = 1'b0; // unknown funct acts as nop
					endcase
				end
				OP_ADDIU: begin
					uses_rs          = 1'b1;
					ctrl.alu_src_imm = 1'b1;
					ctrl.reg_write   = 1'b1;
				end
				OP_LW: begin
					uses_rs          = 1'b1;
					ctrl.alu_src_imm = 1'b1;
					ctrl.mem_read    = 1'b1;
					ctrl.reg_write   = 1'b1;
					ctrl.mem_to_reg  = 1'b1;
				end
				OP_SW: begin
					uses_rs          = 1'b1;
					uses_rt          = 1'b1;
					ctrl.alu_src_imm = 1'b1;
					ctrl.mem_write   = 1'b1;
				end
				OP_BEQ: begin
					uses_rs     = 1'b1;
					uses_rt     = 1'b1;
					ctrl.alu_op = SUB;
					ctrl.branch = 1'b1;
				end
				OP_HALT: is_halt = 1'b1;
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// register file, write-through read
	//////////////////////////////////////////////////

	assign rf_we = step && mem_wb.reg_write && (mem_wb.dest != '0);

	always_ff @(posedge clk) begin
		if (rf_we)
			regs[mem_wb.dest] <= mem_wb.data;
	end

	assign rd1 = (rs == '0) ? '0 :
		(rf_we && mem_wb.dest == rs) ? mem_wb.data : regs[rs];
	assign rd2 = (rt == '0) ? '0 :
		(rf_we && mem_wb.dest == rt) ? mem_wb.data : regs[rt];
	assign dbg_reg = (dbg_addr == '0) ? '0 : regs[dbg_addr]; // r0 is never written

	//////////////////////////////////////////////////
	// hazards and ID/EX
	//////////////////////////////////////////////////

	// load in EX whose result is needed here
	assign stall = id_ex.ctrl.mem_read && (id_ex.dest != '0) &&
		((uses_rs && id_ex.dest == rs) || (uses_rt && id_ex.dest == rt));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			hold_q <= 1'b0;
		else if (step) begin
			if (flush)
				hold_q <= 1'b0; // halt was on a wrong path
			else if (is_halt)
				hold_q <= 1'b1;
		end
	end

	assign hold = !flush && (hold_q || is_halt);

	always_comb begin
		id_ex_d          = '0;
		id_ex_d.ctrl     = ctrl;
		id_ex_d.reg1     = rd1;
		id_ex_d.reg2     = rd2;
		id_ex_d.imm      = imm_ext;
		id_ex_d.rs       = rs;
		id_ex_d.rt       = rt;
		id_ex_d.dest     = dest;
		id_ex_d.pc_plus4 = if_id.pc_plus4;
		id_ex_d.halt     = is_halt;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			id_ex <= '0;
		else if (step) begin
			if (flush || stall)
				id_ex <= '0; // bubble
			else
				id_ex <= id_ex_d;
		end
	end

	// stalled instruction waits in IF/ID for its retry
	a_stall_keeps_if_id: assert property (@(posedge clk) disable iff (!arst_n)
		(step && stall && !flush) |=> $stable(if_id));

endmodule

`default_nettype wire

// File: logic/execute.sv
`timescale 1ns/1ns
`default_nettype none

module execute (
	input  wire logic              clk,
	input  wire logic              arst_n,
	input  wire logic              run,
	input  wire logic              halt,
	input  wire logic              flush,
	input  wire mips_pkg::id_ex_t  id_ex,
	input  wire mips_pkg::ex_mem_t mem_fwd,
	input  wire mips_pkg::mem_wb_t wb_fwd,
	output mips_pkg::ex_mem_t      ex_mem
);
	import mips_pkg::*;

	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [DATA_W-1:0] alu_b;
	logic [DATA_W-1:0] alu_y;
	ex_mem_t           ex_mem_d;
	logic              step;

	// MEM result is younger, so it wins over WB
	function automatic logic [DATA_W-1:0] fwd_sel(
		input logic [REG_ADDR_W-1:0] src,
		input logic [DATA_W-1:0]     reg_val,
		input ex_mem_t               m,
		input mem_wb_t               w
	);
		if (m.ctrl.reg_write && m.dest != '0 && m.dest == src)
			return m.alu;
		if (w.reg_write && w.dest != '0 && w.dest == src)
			return w.data;
		return reg_val;
	endfunction

	assign step  = run && !halt;
	assign op_a  = fwd_sel(id_ex.rs, id_ex.reg1, mem_fwd, wb_fwd);
	assign op_b  = fwd_sel(id_ex.rt, id_ex.reg2, mem_fwd, wb_fwd);
	assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b;

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////

	always_comb begin
		case (id_ex.ctrl.alu_op)
			ADD:     alu_y = op_a + alu_b;
			SUB:     alu_y = op_a - alu_b;
			AND:     alu_y = op_a & alu_b;
			OR:      alu_y = op_a | alu_b;
			SLT:     alu_y = {{(DATA_W-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
			default: alu_y = '0;
		endcase
	end

	always_comb begin
		ex_mem_d               = '0;
		ex_mem_d.ctrl          = id_ex.ctrl;
		ex_mem_d.alu           = alu_y;
		ex_mem_d.store_data    = op_b; // forwarded rt
		ex_mem_d.dest          = id_ex.dest;
		ex_mem_d.branch_target = id_ex.pc_plus4 + {id_ex.imm[DATA_W-3:0], 2'b00};
		ex_mem_d.zero          = (op_a == op_b);
		ex_mem_d.halt          = id_ex.halt;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ex_mem <= '0;
		else if (step) begin
			if (flush)
				ex_mem <= '0; // younger than the taken beq
			else
				ex_mem <= ex_mem_d;
		end
	end

endmodule

`default_nettype wire

// File: logic/memory.sv
`timescale 1ns/1ns
`default_nettype none

module memory (
	input  wire logic                         clk,
	input  wire logic                         arst_n,
	input  wire logic                         run,
	input  wire mips_pkg::ex_mem_t            ex_mem,
	input  wire logic [mips_pkg::DMEM_AW-1:0] dbg_addr,
	output mips_pkg::mem_wb_t                 mem_wb,
	output logic                              flush,
	output logic [mips_pkg::DATA_W-1:0]       branch_target,
	output logic                              halt,
	output logic [mips_pkg::DATA_W-1:0]       dbg_mem
);
	import mips_pkg::*;

	logic [DATA_W-1:0]  dmem [DMEM_DEPTH];
	logic [DMEM_AW-1:0] word_addr;
	logic [DATA_W-1:0]  rd_data;
	logic               step;

	assign step      = run && !halt;
	assign word_addr = ex_mem.alu[DMEM_AW+1:2]; // word accesses only
	assign rd_data   = dmem[word_addr];
	assign dbg_mem   = dmem[dbg_addr];

	always_ff @(posedge clk) begin
		if (step && ex_mem.ctrl.mem_write)
			dmem[word_addr] <= ex_mem.store_data;
	end

	//////////////////////////////////////////////////
	// branch resolve and write-back
	//////////////////////////////////////////////////

	assign flush         = ex_mem.ctrl.branch && ex_mem.zero;
	assign branch_target = ex_mem.branch_target;
	assign halt          = mem_wb.halt; // frozen once set

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			mem_wb <= '0;
		else if (step) begin
			mem_wb.reg_write <= ex_mem.ctrl.reg_write;
			mem_wb.dest      <= ex_mem.dest;
			mem_wb.data      <= ex_mem.ctrl.mem_to_reg ? rd_data : ex_mem.alu;
			mem_wb.halt      <= ex_mem.halt;
		end
	end

	// decode never builds an access that both loads and stores
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(ex_mem.ctrl.mem_read && ex_mem.ctrl.mem_write));

endmodule

`default_nettype wire

// File: logic/top_mips.sv
`timescale 1ns/1ns
`default_nettype none

module top_mips (
	input  wire logic                            clk,
	input  wire logic                            arst_n,
	input  wire logic                            run,
	input  wire logic                            load_req,
	input  wire logic [mips_pkg::IMEM_AW-1:0]    load_addr,
	input  wire logic [mips_pkg::DATA_W-1:0]     load_data,
	output logic                                 load_ack,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0] dbg_addr,
	output logic [mips_pkg::DATA_W-1:0]          dbg_reg,
	output logic [mips_pkg::DATA_W-1:0]          dbg_mem,
	output logic [mips_pkg::DATA_W-1:0]          pc,
	output logic                                 halt
);
	import mips_pkg::*;

	if_id_t             if_id;
	id_ex_t             id_ex;
	ex_mem_t            ex_mem;
	mem_wb_t            mem_wb;
	logic               stall;
	logic               hold;
	logic               flush;
	logic [DATA_W-1:0]  branch_target;
	logic [DMEM_AW-1:0] dbg_maddr;

	assign dbg_maddr = {{(DMEM_AW-REG_ADDR_W){1'b0}}, dbg_addr};

	instruction_fetch u_instruction_fetch (
		.clk(clk),
		.arst_n(arst_n),
		.run(run),
		.halt(halt),
		.stall(stall),
		.hold(hold),
		.flush(flush),
		.branch_target(branch_target),
		.load_req(load_req),
		.load_addr(load_addr),
		.load_data(load_data),
		.load_ack(load_ack),
		.pc(pc),
		.if_id(if_id)
	);

	decode u_decode (
		.clk(clk),
		.arst_n(arst_n),
		.run(run),
		.halt(halt),
		.flush(flush),
		.if_id(if_id),
		.mem_wb(mem_wb), // register write
		.dbg_addr(dbg_addr),
		.id_ex(id_ex),
		.stall(stall),
		.hold(hold),
		.dbg_reg(dbg_reg)
	);

	execute u_execute (
		.clk(clk),
		.arst_n(arst_n),
		.run(run),
		.halt(halt),
		.flush(flush),
		.id_ex(id_ex),
		.mem_fwd(ex_mem), // forward from MEM
		.wb_fwd(mem_wb),  // forward from WB
		.ex_mem(ex_mem)
	);

	memory u_memory (
		.clk(clk),
		.arst_n(arst_n),
		.run(run),
		.ex_mem(ex_mem),
		.dbg_addr(dbg_maddr),
		.mem_wb(mem_wb),
		.flush(flush),
		.branch_target(branch_target),
		.halt(halt),
		.dbg_mem(dbg_mem)
	);

endmodule

`default_nettype wire

// File: tests/tb_top_mips.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top_mips;
	import mips_pkg::*;

	localparam int CLK_HALF   = 20;
	localparam int RST_CYCLES = 10;
	localparam int FILE_WORDS = 256;

	logic                  clk;
	logic                  arst_n;
	logic                  run;
	logic                  load_req;
	logic [IMEM_AW-1:0]    load_addr;
	logic [DATA_W-1:0]     load_data;
	logic                  load_ack;
	logic [REG_ADDR_W-1:0] dbg_addr;
	logic [DATA_W-1:0]     dbg_reg;
	logic [DATA_W-1:0]     dbg_mem;
	logic [DATA_W-1:0]     pc;
	logic                  halt;

	logic [DATA_W-1:0] vec [FILE_WORDS]; // contents of the stimulus file
	logic [31:0]       lcg_state = 32'h128c285e;
	int                errors = 0;
	int                checks = 0;
	int                cycles = 0;
	int                cycle_limit = 100000; // replaced once the file is read
	int                halt_rises = 0;
	logic              req_seen = 1'b0; // samples from the previous falling edge
	logic              ack_seen = 1'b0;
	logic              halt_seen = 1'b0;

	top_mips uut (
		.clk(clk),
		.arst_n(arst_n),
		.run(run),
		.load_req(load_req),
		.load_addr(load_addr),
		.load_data(load_data),
		.load_ack(load_ack),
		.dbg_addr(dbg_addr),
		.dbg_reg(dbg_reg),
		.dbg_mem(dbg_mem),
		.pc(pc),
		.halt(halt)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
		input logic [DATA_W-1:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH t=%0t %s: got %h expected %h", $time, name, actual, expected);
		end
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic reset_dut();
		repeat (RST_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		check_value("pc in reset", pc, 32'd0);
		check_value("load_ack in reset", 32'(load_ack), 32'd0);
		check_value("halt in reset", 32'(halt), 32'd0);
		@(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_value("pc after reset", pc, 32'd0);
		check_value("load_ack after reset", 32'(load_ack), 32'd0);
		check_value("halt after reset", 32'(halt), 32'd0);
	endtask

	// one four-phase transfer after a random idle gap
	task automatic load_word(input logic [IMEM_AW-1:0] addr, input logic [DATA_W-1:0] data);
		int gap;
		lcg_state = lcg_next(lcg_state);
		gap = int'(lcg_state[31:30]);
		repeat (gap + 1) @(posedge clk);
		load_addr <= addr;
		load_data <= data;
		load_req  <= 1'b1;
		@(negedge clk);
		while (!load_ack)
			@(negedge clk);
		@(posedge clk);
		load_req <= 1'b0; // addr and data stay put
		@(negedge clk);
		while (load_ack)
			@(negedge clk);
	endtask

	task automatic load_program(input int n);
		for (int i = 0; i < n; i++)
			load_word(IMEM_AW'(i), vec[1 + i]);
	endtask

	task automatic run_program(input int n);
		logic [DATA_W-1:0] pc_at_halt;
		@(posedge clk);
		run <= 1'b1;
		@(negedge clk);
		while (!halt)
			@(negedge clk);
		pc_at_halt = pc;
		check_value("pc at halt", pc, DATA_W'(4 * n)); // held one past HALT
		repeat (10) begin
			@(negedge clk);
			check_value("pc after halt", pc, pc_at_halt);
			check_value("halt after halt", 32'(halt), 32'd1);
		end
		check_value("halt rise count", 32'(halt_rises), 32'd1);
	endtask

	task automatic check_state(input int n);
		int base;
		int n_reg;
		int n_mem;
		base  = n + 1;
		n_reg = int'(vec[base]);
		for (int i = 0; i < n_reg; i++) begin
			@(posedge clk);
			dbg_addr <= REG_ADDR_W'(vec[base + 1 + 2 * i]);
			@(negedge clk);
			check_value($sformatf("r%0d", vec[base + 1 + 2 * i]), dbg_reg,
				vec[base + 2 + 2 * i]);
		end
		base  = base + 1 + 2 * n_reg;
		n_mem = int'(vec[base]);
		for (int i = 0; i < n_mem; i++) begin
			@(posedge clk);
			dbg_addr <= REG_ADDR_W'(vec[base + 1 + 2 * i]);
			@(negedge clk);
			check_value($sformatf("dmem[%0d]", vec[base + 1 + 2 * i]), dbg_mem,
				vec[base + 2 + 2 * i]);
		end
	endtask

	//////////////////////////////////////////////////
	// monitors
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run did not end within %0d cycles", cycle_limit);
			$display("Verification failed");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (arst_n) begin
			if (load_ack && !ack_seen)
				check_value("load_req before load_ack rise", 32'(req_seen), 32'd1);
			if (!load_ack && ack_seen)
				check_value("load_req before load_ack fall", 32'(req_seen), 32'd0);
			if (halt && !halt_seen)
				halt_rises++;
		end
		req_seen  = load_req;
		ack_seen  = load_ack;
		halt_seen = halt;
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int n_prog;
		int n_reg;
		int n_mem;
		arst_n    = 1'b0;
		run       = 1'b0;
		load_req  = 1'b0;
		load_addr = '0;
		load_data = '0;
		dbg_addr  = '0;
		$readmemh("tests/program_input.hex", vec);
		n_prog = int'(vec[0]);
		if (n_prog < 1 || n_prog > IMEM_DEPTH) begin
			$display("program file tests/program_input.hex is missing or has a bad word count");
			errors++;
		end else begin
			n_reg = int'(vec[n_prog + 1]);
			n_mem = int'(vec[n_prog + 2 + 2 * n_reg]);
			// load handshakes take at most 8 cycles per word
			cycle_limit = RST_CYCLES + 8 * n_prog + 20 * n_prog + n_reg + n_mem + 40;
			reset_dut();
			load_program(n_prog);
			run_program(n_prog);
			check_state(n_prog);
		end
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
logic/mips_pkg.sv
logic/instruction_fetch.sv
logic/decode.sv
logic/execute.sv
logic/memory.sv
logic/top_mips.sv
tests/tb_top_mips.sv

// File: run_sim.sh
#!/bin/sh
# build and run the top_mips testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_top_mips -o tb_top_mips
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_top_mips > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi
exit 0

// File: tests/program_input.hex
// word count, then program words in load order
// then register count and (register, value) pairs, then data count and (word address, value) pairs
21
24010007 // addiu r1, r0, 7
2402FFFD // addiu r2, r0, -3
00221821 // addu  r3, r1, r2
00412023 // subu  r4, r2, r1
00642824 // and   r5, r3, r4
00813025 // or    r6, r4, r1
0082382A // slt   r7, r4, r2
0044402A // slt   r8, r2, r4
0081482A // slt   r9, r4, r1
240A0100 // addiu r10, r0, 0x100
014A5021 // addu  r10, r10, r10
014A5021 // addu  r10, r10, r10
01415823 // subu  r11, r10, r1
AC0A0008 // sw    r10, 8(r0)
AC04000C // sw    r4, 12(r0)
240C0004 // addiu r12, r0, 4
AD8B0010 // sw    r11, 16(r12)
8C0D0008 // lw    r13, 8(r0)
01A17021 // addu  r14, r13, r1
8D8F0008 // lw    r15, 8(r12)
AC0F0018 // sw    r15, 24(r0)
2410000B // addiu r16, r0, 11
24110016 // addiu r17, r0, 22
24120021 // addiu r18, r0, 33
10210003 // beq   r1, r1, +3 taken
24100063 // addiu r16, r0, 99 flushed
24110063 // addiu r17, r0, 99 flushed
24120063 // addiu r18, r0, 99 flushed
10220005 // beq   r1, r2, +5 not taken
24130037 // addiu r19, r0, 55
24000005 // addiu r0, r0, 5
0001A021 // addu  r20, r0, r1
FC000000 // halt
15
00 00000000  01 00000007  02 FFFFFFFD
03 00000004  04 FFFFFFF6  05 00000004
06 FFFFFFF7  07 00000001  08 00000000
09 00000001  0a 00000400  0b 000003F9
0c 00000004  0d 00000400  0e 00000407
0f FFFFFFF6  10 0000000B  11 00000016
12 00000021  13 00000037  14 00000007
4
02 00000400  03 FFFFFFF6
05 000003F9  06 FFFFFFF6
